// ==== src/jfive_pkg.sv ====
package jfive_pkg;

    // thread count and widths
    localparam int THREADS       = 4;
    localparam int ID_BITS       = 2;
    localparam int PC_BITS       = 16;
    localparam int MEM_ADDR_BITS = 12;

    // thread index
    typedef logic [ID_BITS-1:0]       id_t;
    // byte address of an instruction
    typedef logic [PC_BITS-1:0]       pc_t;
    typedef logic [31:0]              instr_t;
    // ram word address
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [31:0]              data_t;
    typedef logic [3:0]               strb_t;
    // one bit per thread
    typedef logic [THREADS-1:0]       thread_mask_t;

    // thread t starts at t * 0x100
    localparam pc_t [THREADS-1:0] INIT_PC = {
        16'h0300,
        16'h0200,
        16'h0100,
        16'h0000
    };

    // rv32i encodings the slots look at
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam instr_t     INSTR_EBREAK = 32'h0010_0073;

    // fetch request from the scheduler
    typedef struct packed {
        id_t id;
        pc_t pc;
    } fetch_cmd_t;

    // fetched word with its tags
    typedef struct packed {
        id_t    id;
        pc_t    pc;
        instr_t instr;
    } fetch_res_t;

endpackage

// ==== src/ram_dualport.sv ====
`timescale 1ns/1ps

module ram_dualport
    import jfive_pkg::*;
(
    input  logic      clk,

    input  logic      en0,
    input  strb_t     we0,
    input  mem_addr_t addr0,
    input  data_t     din0,
    output data_t     dout0,

    input  logic      en1,
    input  strb_t     we1,
    input  mem_addr_t addr1,
    input  data_t     din1,
    output data_t     dout1
);

    data_t mem [0:(2**MEM_ADDR_BITS)-1];

    // array read stage of each port
    data_t rd0;
    data_t rd1;

    // both ports share one process so the array has a single writer
    // port 1 wins when both write the same byte
    always_ff @(posedge clk) begin
        if (en0) begin
            for (int b = 0; b < 4; b++) begin
                if (we0[b]) begin
                    mem[addr0][b*8 +: 8] <= din0[b*8 +: 8];
                end
            end
            rd0   <= mem[addr0];
            dout0 <= rd0;
        end
        if (en1) begin
            for (int b = 0; b < 4; b++) begin
                if (we1[b]) begin
                    mem[addr1][b*8 +: 8] <= din1[b*8 +: 8];
                end
            end
            rd1   <= mem[addr1];
            dout1 <= rd1;
        end
    end

endmodule

// ==== src/mem_controller.sv ====
`timescale 1ns/1ps

module mem_controller
    import jfive_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // fetch port
    input  fetch_cmd_t fetch_cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output fetch_res_t fetch_res,
    output logic       res_valid,
    input  logic       res_ready,

    // host wishbone classic slave
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  mem_addr_t  wb_adr,
    input  strb_t      wb_sel,
    input  data_t      wb_dat_w,
    output data_t      wb_dat_r,
    output logic       wb_ack
);

    logic      en0;
    mem_addr_t addr0;
    data_t     dout0;

    logic      en1;
    strb_t     we1;
    data_t     dout1;

    // tag pipeline, aligned with the two ram stages
    fetch_cmd_t st0_tag;
    logic       st0_valid;
    fetch_cmd_t st1_tag;
    logic       st1_valid;

    // host read progress
    logic [1:0] rd_cnt;
    logic       host_start;

    ram_dualport u_ram (
        .clk   (clk),
        .en0   (en0),
        .we0   ('0),
        .addr0 (addr0),
        .din0  ('0),
        .dout0 (dout0),
        .en1   (en1),
        .we1   (we1),
        .addr1 (wb_adr),
        .din1  (wb_dat_w),
        .dout1 (dout1)
    );

    // whole fetch pipeline moves only when the router can take a word
    assign en0       = res_ready;
    assign cmd_ready = res_ready;
    assign addr0     = mem_addr_t'(fetch_cmd.pc[PC_BITS-1:2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
        end else if (res_ready) begin
            st0_valid <= cmd_valid;
            st1_valid <= st0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_ready) begin
            st0_tag <= fetch_cmd;
            st1_tag <= st0_tag;
        end
    end

    assign fetch_res = '{id: st1_tag.id, pc: st1_tag.pc, instr: dout0};
    assign res_valid = st1_valid;

    // new request only when idle and not in the ack cycle
    assign host_start = wb_cyc && wb_stb && !wb_ack && (rd_cnt == 2'd0);

    // keep port 1 enabled for the output register stage of a read
    assign en1 = host_start || (rd_cnt == 2'd1);
    assign we1 = (host_start && wb_we) ? wb_sel : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_cnt <= 2'd0;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            case (rd_cnt)
                2'd0: begin
                    if (host_start) begin
                        if (wb_we) begin
                            wb_ack <= 1'b1;
                        end else begin
                            rd_cnt <= 2'd1;
                        end
                    end
                end
                2'd1: begin
                    // registered data lands with the ack
                    rd_cnt <= 2'd2;
                    wb_ack <= 1'b1;
                end
                default: begin
                    rd_cnt <= 2'd0;
                end
            endcase
        end
    end

    assign wb_dat_r = dout1;

endmodule

// ==== src/thread_scheduler.sv ====
`timescale 1ns/1ps

module thread_scheduler
    import jfive_pkg::*;
(
    input  logic                clk,
    input  logic                reset,

    input  thread_mask_t        slot_ready,
    output thread_mask_t        grant,
    input  pc_t [THREADS-1:0]   slot_pc,

    output fetch_cmd_t          fetch_cmd,
    output logic                cmd_valid,
    input  logic                cmd_ready
);

    // last granted slot
    id_t  last;
    id_t  pick;
    logic pick_found;
    logic issue;

    // first ready slot after the last one granted
    always_comb begin
        id_t cand;
        pick       = '0;
        pick_found = 1'b0;
        for (int i = 1; i <= THREADS; i++) begin
            cand = id_t'(last + id_t'(i));
            if (!pick_found && slot_ready[cand]) begin
                pick       = cand;
                pick_found = 1'b1;
            end
        end
    end

    // command register empty or being taken this cycle
    assign issue = pick_found && (!cmd_valid || cmd_ready);
    assign grant = issue ? (thread_mask_t'(1) << pick) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid <= 1'b0;
            last      <= id_t'(THREADS - 1);
        end else if (issue) begin
            cmd_valid <= 1'b1;
            last      <= pick;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_cmd <= '{id: pick, pc: slot_pc[pick]};
        end
    end

endmodule

// ==== src/thread_slot.sv ====
`timescale 1ns/1ps

module thread_slot
    import jfive_pkg::*;
#(
    parameter id_t slot_id = '0
)
(
    input  logic       clk,
    input  logic       reset,

    input  logic       start,
    input  logic       grant,
    input  logic       res_valid,
    input  fetch_res_t fetch_res,

    output logic       ready,
    output pc_t        pc,
    output logic       halted
);

    logic run;
    logic pending;

    logic is_jal;
    pc_t  j_imm;
    pc_t  next_pc;

    // J-type immediate, sign extended and cut to the pc width
    assign j_imm = pc_t'({{11{fetch_res.instr[31]}},
                          fetch_res.instr[31],
                          fetch_res.instr[19:12],
                          fetch_res.instr[20],
                          fetch_res.instr[30:21],
                          1'b0});

    assign is_jal  = (fetch_res.instr[6:0] == OPC_JAL);
    assign next_pc = fetch_res.pc + (is_jal ? j_imm : pc_t'(4));

    always_ff @(posedge clk) begin
        if (reset) begin
            run     <= 1'b0;
            pending <= 1'b0;
            halted  <= 1'b0;
            pc      <= INIT_PC[slot_id];
        end else if (start) begin
            run     <= 1'b1;
            pending <= 1'b0;
            halted  <= 1'b0;
            pc      <= INIT_PC[slot_id];
        end else begin
            if (grant) begin
                pending <= 1'b1;
            end
            if (res_valid) begin
                pending <= 1'b0;
                if (fetch_res.instr == INSTR_EBREAK) begin
                    run    <= 1'b0;
                    halted <= 1'b1;
                end else begin
                    pc <= next_pc;
                end
            end
        end
    end

    // one fetch outstanding per thread
    assign ready = run && !pending;

endmodule

// ==== src/fetch_router.sv ====
`timescale 1ns/1ps

module fetch_router
    import jfive_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  fetch_res_t   fetch_res,
    input  logic         res_valid,
    output logic         res_ready,

    output thread_mask_t res_slot_valid,

    output fetch_res_t   trace,
    output logic         trace_valid,
    input  logic         trace_ready
);

    logic take;

    // trace register empty or draining
    assign res_ready = !trace_valid || trace_ready;
    assign take      = res_valid && res_ready;

    // owner slot sees the word in the transfer cycle
    assign res_slot_valid = take ? (thread_mask_t'(1) << fetch_res.id) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            trace_valid <= 1'b0;
        end else if (take) begin
            trace_valid <= 1'b1;
        end else if (trace_ready) begin
            trace_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            trace <= fetch_res;
        end
    end

endmodule

// ==== src/jfive_fetch_top.sv ====
`timescale 1ns/1ps

module jfive_fetch_top
    import jfive_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // host port
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  mem_addr_t    wb_adr,
    input  strb_t        wb_sel,
    input  data_t        wb_dat_w,
    output data_t        wb_dat_r,
    output logic         wb_ack,

    // thread control
    input  thread_mask_t start,
    output thread_mask_t halted,

    // trace stream
    output fetch_res_t   trace,
    output logic         trace_valid,
    input  logic         trace_ready
);

    thread_mask_t       slot_ready;
    thread_mask_t       grant;
    pc_t [THREADS-1:0]  slot_pc;

    fetch_cmd_t         fetch_cmd;
    logic               cmd_valid;
    logic               cmd_ready;

    fetch_res_t         fetch_res;
    logic               res_valid;
    logic               res_ready;
    thread_mask_t       res_slot_valid;

    thread_scheduler u_scheduler (
        .clk        (clk),
        .reset      (reset),
        .slot_ready (slot_ready),
        .grant      (grant),
        .slot_pc    (slot_pc),
        .fetch_cmd  (fetch_cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready)
    );

    for (genvar t = 0; t < THREADS; t++) begin : g_slot
        thread_slot #(
            .slot_id (id_t'(t))
        ) u_slot (
            .clk       (clk),
            .reset     (reset),
            .start     (start[t]),
            .grant     (grant[t]),
            .res_valid (res_slot_valid[t]),
            .fetch_res (fetch_res),
            .ready     (slot_ready[t]),
            .pc        (slot_pc[t]),
            .halted    (halted[t])
        );
    end

    mem_controller u_mem (
        .clk       (clk),
        .reset     (reset),
        .fetch_cmd (fetch_cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .fetch_res (fetch_res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    fetch_router u_router (
        .clk            (clk),
        .reset          (reset),
        .fetch_res      (fetch_res),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .res_slot_valid (res_slot_valid),
        .trace          (trace),
        .trace_valid    (trace_valid),
        .trace_ready    (trace_ready)
    );

endmodule

// ==== sim/jfive_fetch_assertions.sv ====
`timescale 1ns/1ps

module jfive_fetch_assertions
    import jfive_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input fetch_res_t fetch_res,
    input logic       res_valid,
    input logic       res_ready,
    input logic       wb_ack
);

    int failures = 0;

    // two pipeline stages, nothing can come out right after reset
    a_no_early_res: assert property (@(posedge clk) reset |=> !res_valid ##1 !res_valid)
        else begin
            $error("res_valid high within two cycles of reset");
            failures++;
        end

    // a stalled result must hold still
    a_res_stable: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> $stable(fetch_res))
        else begin
            $error("fetch_res changed while stalled");
            failures++;
        end

    a_ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack longer than one cycle");
            failures++;
        end

endmodule

bind mem_controller jfive_fetch_assertions u_assert (
    .clk       (clk),
    .reset     (reset),
    .fetch_res (fetch_res),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .wb_ack    (wb_ack)
);

// ==== sim/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker
    import jfive_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  mem_addr_t    wb_adr,
    input  strb_t        wb_sel,
    input  data_t        wb_dat_w,
    input  data_t        wb_dat_r,
    input  logic         wb_ack,
    input  data_t        exp_rd,
    input  thread_mask_t start,
    input  thread_mask_t halted,
    input  fetch_res_t   trace,
    input  logic         trace_valid,
    input  logic         trace_ready,
    output int           errors,
    output thread_mask_t done
);

    // image of everything the host has written
    data_t        model_mem [0:(2**MEM_ADDR_BITS)-1];
    pc_t          exp_pc [THREADS];
    thread_mask_t running;
    int           err_count = 0;

    assign errors = err_count;

    task automatic report_mismatch(input string name, input int id,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        $display("[FAIL] %s thread %0d: expected %h, actual %h", name, id, exp_val, act_val);
        err_count++;
    endtask

    // jal jumps by its J-immediate and anything else steps one word
    function automatic pc_t follow(input pc_t pc, input instr_t w);
        logic signed [20:0] imm;
        imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        if (w[6:0] == 7'h6f) begin
            return pc + pc_t'(imm);
        end
        return pc + 16'd4;
    endfunction

    // sampled at the falling edge where every input is settled
    always @(negedge clk) begin
        id_t    id;
        instr_t w;
        if (reset) begin
            running = '0;
            done    = '0;
        end else begin
            for (int t = 0; t < THREADS; t++) begin
                if (start[t]) begin
                    running[t] = 1'b1;
                    done[t]    = 1'b0;
                    exp_pc[t]  = pc_t'(t * 32'h100);
                end
            end
            if (wb_cyc && wb_stb && wb_ack) begin
                if (wb_we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_sel[b]) begin
                            model_mem[wb_adr][b*8 +: 8] = wb_dat_w[b*8 +: 8];
                        end
                    end
                end else if (wb_dat_r !== exp_rd) begin
                    $display("[FAIL] host_readback at %h: expected %h, actual %h",
                             wb_adr, exp_rd, wb_dat_r);
                    err_count++;
                end
            end
            if (trace_valid && trace_ready) begin
                id = trace.id;
                if (!running[id]) begin
                    $display("trace word at pc %h for thread %0d, which is not running",
                             trace.pc, id);
                    err_count++;
                end else begin
                    w = model_mem[mem_addr_t'(exp_pc[id] >> 2)];
                    if (trace.pc !== exp_pc[id]) begin
                        report_mismatch("trace_pc", id, 32'(exp_pc[id]), 32'(trace.pc));
                    end
                    if (trace.instr !== w) begin
                        report_mismatch("trace_instr", id, w, trace.instr);
                    end
                    if (w == 32'h0010_0073) begin
                        // ebreak ends the thread
                        running[id] = 1'b0;
                        done[id]    = 1'b1;
                        if (halted[id] !== 1'b1) begin
                            report_mismatch("halted", id, 32'd1, 32'(halted[id]));
                        end
                    end else begin
                        // halted stays low until the ebreak word is taken
                        if (halted[id] !== 1'b0) begin
                            report_mismatch("not_halted", id, 32'd0, 32'(halted[id]));
                        end
                        exp_pc[id] = follow(exp_pc[id], w);
                    end
                end
            end
        end
    end

endmodule

// ==== sim/tb_jfive_fetch.sv ====
`timescale 1ns/1ps

module tb_jfive_fetch
    import jfive_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 3000;
    localparam int N_ENTRIES   = 30;

    typedef struct packed {
        mem_addr_t adr;
        strb_t     sel;
        data_t     dat;
        data_t     rd_exp;
    } host_entry_t;

    // per thread: pc 0, jal +12, 8, jal +12, 0x10, jal -12, ebreak at 0x18
    // order of fetch is 0, 4, 10, 14, 8, c, 18
    localparam host_entry_t LOAD_TABLE [N_ENTRIES] = '{
        '{12'h000, 4'hf, 32'h0010_0093, 32'h0010_0093},
        '{12'h001, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h002, 4'hf, 32'h0020_0113, 32'h0020_0113},
        '{12'h003, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h004, 4'hf, 32'h0030_0193, 32'h0030_0193},
        '{12'h005, 4'hf, 32'hff5f_f06f, 32'hff5f_f06f},
        '{12'h006, 4'hf, 32'h0010_0073, 32'h0010_0073},
        '{12'h040, 4'hf, 32'h0110_0093, 32'h0110_0093},
        '{12'h041, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h042, 4'hf, 32'h0120_0113, 32'h0120_0113},
        '{12'h043, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h044, 4'hf, 32'h0130_0193, 32'h0130_0193},
        '{12'h045, 4'hf, 32'hff5f_f06f, 32'hff5f_f06f},
        '{12'h046, 4'hf, 32'h0010_0073, 32'h0010_0073},
        '{12'h080, 4'hf, 32'h0210_0093, 32'h0210_0093},
        '{12'h081, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h082, 4'hf, 32'h0220_0113, 32'h0220_0113},
        '{12'h083, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h084, 4'hf, 32'h0230_0193, 32'h0230_0193},
        '{12'h085, 4'hf, 32'hff5f_f06f, 32'hff5f_f06f},
        '{12'h086, 4'hf, 32'h0010_0073, 32'h0010_0073},
        '{12'h0c0, 4'hf, 32'h0310_0093, 32'h0310_0093},
        '{12'h0c1, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h0c2, 4'hf, 32'h0320_0113, 32'h0320_0113},
        '{12'h0c3, 4'hf, 32'h00c0_006f, 32'h00c0_006f},
        '{12'h0c4, 4'hf, 32'h0330_0193, 32'h0330_0193},
        '{12'h0c5, 4'hf, 32'hff5f_f06f, 32'hff5f_f06f},
        '{12'h0c6, 4'hf, 32'h0010_0073, 32'h0010_0073},
        // byte merge, bytes 0 and 2 replaced
        '{12'h7f0, 4'hf, 32'h1122_3344, 32'h11bb_33dd},
        '{12'h7f0, 4'h5, 32'haabb_ccdd, 32'h11bb_33dd}
    };

    logic         clk;
    logic         reset;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    mem_addr_t    wb_adr;
    strb_t        wb_sel;
    data_t        wb_dat_w;
    data_t        wb_dat_r;
    logic         wb_ack;
    thread_mask_t start;
    thread_mask_t halted;
    fetch_res_t   trace;
    logic         trace_valid;
    logic         trace_ready;

    data_t        exp_rd;
    int           chk_errors;
    thread_mask_t done;
    logic         random_ready;
    int           tb_errors;

    jfive_fetch_top uut (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .start       (start),
        .halted      (halted),
        .trace       (trace),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready)
    );

    fetch_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .exp_rd      (exp_rd),
        .start       (start),
        .halted      (halted),
        .trace       (trace),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready),
        .errors      (chk_errors),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // back-pressure on the trace stream, about 70 percent ready
    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            trace_ready = ($urandom % 100) < 70;
        end else begin
            trace_ready = 1'b1;
        end
    end

    // ack seen at the falling edge, request dropped after the next rising edge
    task automatic finish_host_cycle(input string what);
        int n;
        for (n = 0; n < ACK_TIMEOUT; n++) begin
            @(negedge clk);
            if (wb_ack) begin
                break;
            end
        end
        if (n == ACK_TIMEOUT) begin
            $display("timeout: no wb_ack for host %s at address %h", what, wb_adr);
            tb_errors++;
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic host_write(input mem_addr_t adr, input strb_t sel, input data_t dat);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = dat;
        finish_host_cycle("write");
    endtask

    task automatic host_read(input mem_addr_t adr, input data_t exp_val);
        @(posedge clk);
        #1;
        exp_rd = exp_val;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wb_sel = '0;
        finish_host_cycle("read");
    endtask

    task automatic pulse_start(input thread_mask_t mask);
        @(posedge clk);
        #1 start = mask;
        @(posedge clk);
        #1 start = '0;
    endtask

    // halted and the last trace word both have to show up
    task automatic wait_threads(input thread_mask_t mask);
        int n;
        for (n = 0; n < RUN_TIMEOUT; n++) begin
            @(negedge clk);
            if ((halted & mask) == mask && (done & mask) == mask) begin
                break;
            end
        end
        if (n == RUN_TIMEOUT) begin
            $display("timeout: threads %b did not halt with a complete trace", mask);
            tb_errors++;
        end
    endtask

    initial begin
        int seed_sink;
        int total;
        seed_sink    = $urandom(62147);
        tb_errors    = 0;
        random_ready = 1'b0;
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_sel       = '0;
        wb_dat_w     = '0;
        exp_rd       = '0;
        start        = '0;
        trace_ready  = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++) begin
            host_write(LOAD_TABLE[i].adr, LOAD_TABLE[i].sel, LOAD_TABLE[i].dat);
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            host_read(LOAD_TABLE[i].adr, LOAD_TABLE[i].rd_exp);
        end

        // one thread alone, no back-pressure
        pulse_start(4'b0001);
        wait_threads(4'b0001);

        // all threads together, host read while they run
        random_ready = 1'b1;
        pulse_start(4'b1111);
        host_read(LOAD_TABLE[9].adr, LOAD_TABLE[9].rd_exp);
        wait_threads(4'b1111);
        random_ready = 1'b0;
        repeat (20) @(posedge clk);

        total = chk_errors + tb_errors + uut.u_mem.u_assert.failures;
        $display("errors: checker %0d, assertions %0d, testbench %0d",
                 chk_errors, uut.u_mem.u_assert.failures, tb_errors);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/jfive_pkg.sv
src/ram_dualport.sv
src/mem_controller.sv
src/thread_scheduler.sv
src/thread_slot.sv
src/fetch_router.sv
src/jfive_fetch_top.sv
sim/jfive_fetch_assertions.sv
sim/fetch_checker.sv
sim/tb_jfive_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_jfive_fetch \
    -f list.f \
    -o Vtb_jfive_fetch

./obj_dir/Vtb_jfive_fetch +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi
